// ==== src/thumb_isa_pkg.sv ====
// thumb isa package: instruction word, group prefixes and opcode encodings
package thumb_isa_pkg;

    typedef logic [15:0] cmd_t;

    // operation performed by an execution unit
    typedef enum logic [3:0] {
        op_lsl,
        op_lsr,
        op_asr,
        op_ror,
        op_add,
        op_and,
        op_orr,
        op_eor,
        op_mul,
        op_none
    } op_e;

    // register to register data processing, bits [9:6]
    typedef enum logic [3:0] {
        dp_and = 4'h0,
        dp_eor = 4'h1,
        dp_lsl = 4'h2,
        dp_lsr = 4'h3,
        dp_asr = 4'h4,
        dp_adc = 4'h5,
        dp_sbc = 4'h6,
        dp_ror = 4'h7,
        dp_tst = 4'h8,
        dp_rsb = 4'h9,
        dp_cmp = 4'ha,
        dp_cmn = 4'hb,
        dp_orr = 4'hc,
        dp_mul = 4'hd,
        dp_bic = 4'he,
        dp_mvn = 4'hf
    } dp_opcode_e;

    // shift by immediate kind, bits [12:11]
    typedef enum logic [1:0] {
        sh_lsl = 2'b00,
        sh_lsr = 2'b01,
        sh_asr = 2'b10
    } shift_imm_e;

    // imm8 format mode, bits [12:11]
    typedef enum logic [1:0] {
        imm8_mov = 2'b00,
        imm8_cmp = 2'b01,
        imm8_add = 2'b10,
        imm8_sub = 2'b11
    } imm8_mode_e;

    // group prefixes, compared against the top bits of the word
    localparam logic [2:0] grp_shift_imm = 3'b000;
    localparam logic [4:0] grp_add_sub   = 5'b00011;
    localparam logic [2:0] grp_imm8      = 3'b001;
    localparam logic [5:0] grp_data_proc = 6'b010000;

    // any shift count above the word width collapses to this
    localparam logic [5:0] shift_sat = 6'd33;

    function automatic logic is_shift_op(op_e op);
        return op inside {op_lsl, op_lsr, op_asr, op_ror};
    endfunction

endpackage

// ==== src/core_types_pkg.sv ====
// core datapath types: machine word, register index, flags and pipeline structs
package core_types_pkg;
    import thumb_isa_pkg::*;

    localparam int sys_bits  = 32;
    localparam int reg_count = 16;

    typedef logic [sys_bits-1:0]          word_t;
    typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // operands already selected, subtraction folded into inverted m plus carry
    typedef struct packed {
        op_e      op;
        word_t    operand_n;
        word_t    operand_m;
        logic     carry_in;
        reg_idx_t dest;
        logic     write_en;
        logic     set_flags;
        logic     valid;
    } exec_req_t;

    typedef struct packed {
        word_t value;
        logic  carry;
        logic  overflow;
    } exec_res_t;

    // committed instruction as seen from outside
    typedef struct packed {
        logic     valid;
        logic     write_en;
        reg_idx_t dest;
        word_t    value;
    } wb_t;

endpackage

// ==== src/thumb_decoder.sv ====
// thumb decoder: maps a 16-bit command onto register reads and an execution request
`timescale 1ns/1ps

module thumb_decoder import thumb_isa_pkg::*, core_types_pkg::*; (
    input  cmd_t      cmd_i,
    input  logic      cmd_valid_i,
    input  flags_t    flags_i,
    input  word_t     rd_data_n_i,
    input  word_t     rd_data_m_i,
    output reg_idx_t  rd_idx_n_o,
    output reg_idx_t  rd_idx_m_o,
    output exec_req_t req_o
);

    dp_opcode_e dp_op;
    imm8_mode_e imm_mode;

    assign dp_op    = dp_opcode_e'(cmd_i[9:6]);
    assign imm_mode = imm8_mode_e'(cmd_i[12:11]);

    // read port addresses, taken from the command word alone
    always_comb begin
        rd_idx_n_o = reg_idx_t'(cmd_i[5:3]);
        rd_idx_m_o = reg_idx_t'(cmd_i[8:6]);
        if (cmd_i[15:13] == grp_imm8) begin
            rd_idx_n_o = reg_idx_t'(cmd_i[10:8]);
        end else if (cmd_i[15:10] == grp_data_proc) begin
            rd_idx_n_o = reg_idx_t'(cmd_i[2:0]);
            rd_idx_m_o = reg_idx_t'(cmd_i[5:3]);
        end
    end

    always_comb begin
        req_o           = '0;
        req_o.op        = op_none;
        req_o.dest      = reg_idx_t'(cmd_i[2:0]);
        req_o.write_en  = 1'b1;
        req_o.set_flags = 1'b1;

        // 00011 sits inside the 000 prefix, so it is matched first
        if (cmd_i[15:11] == grp_add_sub) begin
            req_o.valid     = cmd_valid_i;
            req_o.op        = op_add;
            req_o.operand_n = rd_data_n_i;
            // bit 10 picks imm3, bit 9 turns the add into n + ~m + 1
            req_o.operand_m = (cmd_i[10] ? word_t'(cmd_i[8:6]) : rd_data_m_i)
                              ^ {sys_bits{cmd_i[9]}};
            req_o.carry_in  = cmd_i[9];
        end else if (cmd_i[15:13] == grp_shift_imm) begin
            req_o.valid     = cmd_valid_i;
            req_o.operand_n = rd_data_n_i;
            req_o.operand_m = word_t'(cmd_i[10:6]);
            case (shift_imm_e'(cmd_i[12:11]))
                sh_lsl:  req_o.op = op_lsl;
                sh_lsr:  req_o.op = op_lsr;
                sh_asr:  req_o.op = op_asr;
                default: req_o.op = op_none;
            endcase
        end else if (cmd_i[15:13] == grp_imm8) begin
            req_o.dest      = reg_idx_t'(cmd_i[10:8]);
            req_o.valid     = cmd_valid_i;
            req_o.op        = op_add;
            req_o.operand_n = (imm_mode == imm8_mov) ? '0 : rd_data_n_i;
            // bit 11 is set for both cmp and sub
            req_o.operand_m = word_t'(cmd_i[7:0]) ^ {sys_bits{cmd_i[11]}};
            req_o.carry_in  = cmd_i[11];
            req_o.write_en  = (imm_mode != imm8_cmp);
        end else if (cmd_i[15:10] == grp_data_proc) begin
            req_o.valid     = cmd_valid_i;
            req_o.operand_n = rd_data_n_i;
            req_o.operand_m = rd_data_m_i;
            case (dp_op)
                dp_and, dp_tst: req_o.op = op_and;
                dp_eor:         req_o.op = op_eor;
                dp_orr:         req_o.op = op_orr;
                dp_mul:         req_o.op = op_mul;
                dp_lsl:         req_o.op = op_lsl;
                dp_lsr:         req_o.op = op_lsr;
                dp_asr:         req_o.op = op_asr;
                dp_ror:         req_o.op = op_ror;
                dp_cmn:         req_o.op = op_add;
                dp_adc: begin
                    req_o.op       = op_add;
                    req_o.carry_in = flags_i.c;
                end
                // n - m - !c is n + ~m + c
                dp_sbc: begin
                    req_o.op        = op_add;
                    req_o.operand_m = ~rd_data_m_i;
                    req_o.carry_in  = flags_i.c;
                end
                dp_cmp: begin
                    req_o.op        = op_add;
                    req_o.operand_m = ~rd_data_m_i;
                    req_o.carry_in  = 1'b1;
                end
                // negate the register in bits [5:3]
                dp_rsb: begin
                    req_o.op        = op_add;
                    req_o.operand_n = '0;
                    req_o.operand_m = ~rd_data_m_i;
                    req_o.carry_in  = 1'b1;
                end
                dp_bic: begin
                    req_o.op        = op_and;
                    req_o.operand_m = ~rd_data_m_i;
                end
                // xor with all ones, keeps c and v like the other bitwise ops
                dp_mvn: begin
                    req_o.op        = op_eor;
                    req_o.operand_n = rd_data_m_i;
                    req_o.operand_m = '1;
                end
                default: req_o.op = op_none;
            endcase
            req_o.write_en = !(dp_op inside {dp_tst, dp_cmp, dp_cmn});
        end
    end

endmodule

// ==== src/barrel_shifter.sv ====
// barrel shifter: lsl, lsr, asr and ror with carry out of the last shifted bit
`timescale 1ns/1ps

module barrel_shifter import thumb_isa_pkg::*, core_types_pkg::*; (
    input  exec_req_t req_i,
    input  flags_t    flags_i,
    output exec_res_t res_o
);

    logic [5:0]                   amount;
    logic [4:0]                   rot;
    logic [sys_bits:0]            lsl_full;
    logic [2*sys_bits-1:0]        lsr_full;
    logic signed [2*sys_bits-1:0] asr_full;
    logic [2*sys_bits-1:0]        ror_full;

    // only the low byte counts, anything above 32 saturates
    assign amount = (req_i.operand_m[7:0] > 8'(sys_bits)) ? shift_sat
                                                          : req_i.operand_m[5:0];
    assign rot    = req_i.operand_m[4:0];

    // old c rides above the word, so a zero shift hands it back unchanged
    assign lsl_full = {flags_i.c, req_i.operand_n} << amount;
    // lower half catches the bits shifted out
    assign lsr_full = {req_i.operand_n, {sys_bits{1'b0}}} >> amount;
    assign asr_full = $signed({req_i.operand_n, {sys_bits{1'b0}}}) >>> amount;
    assign ror_full = {req_i.operand_n, req_i.operand_n} >> rot;

    always_comb begin
        res_o.value    = req_i.operand_n;
        res_o.carry    = flags_i.c;
        res_o.overflow = flags_i.v;
        case (req_i.op)
            op_lsl: begin
                res_o.value = lsl_full[sys_bits-1:0];
                res_o.carry = lsl_full[sys_bits];
            end
            op_lsr: begin
                res_o.value = lsr_full[2*sys_bits-1:sys_bits];
                res_o.carry = (amount == '0) ? flags_i.c : lsr_full[sys_bits-1];
            end
            op_asr: begin
                res_o.value = asr_full[2*sys_bits-1:sys_bits];
                res_o.carry = (amount == '0) ? flags_i.c : asr_full[sys_bits-1];
            end
            op_ror: begin
                res_o.value = ror_full[sys_bits-1:0];
                res_o.carry = (amount == '0) ? flags_i.c : ror_full[sys_bits-1];
            end
            default: res_o.value = req_i.operand_n;
        endcase
    end

endmodule

// ==== src/arith_logic_unit.sv ====
// arithmetic logic unit: 33-bit adder, four-way bitwise mux and low-word multiply
`timescale 1ns/1ps

module arith_logic_unit import thumb_isa_pkg::*, core_types_pkg::*; (
    input  exec_req_t req_i,
    input  flags_t    flags_i,
    output exec_res_t res_o
);

    logic [sys_bits:0] sum;
    word_t             bitwise;
    word_t             product;
    logic              sel_inv;
    logic              sel_or;

    assign sum = {1'b0, req_i.operand_n} + {1'b0, req_i.operand_m}
                 + {{sys_bits{1'b0}}, req_i.carry_in};

    assign product = req_i.operand_n * req_i.operand_m;

    // mux select: 00 and, 01 or, 10 xor, 11 nand
    assign sel_inv = (req_i.op == op_eor);
    assign sel_or  = (req_i.op == op_orr);

    assign bitwise =
        ((sel_inv ? ~req_i.operand_n : req_i.operand_n)
            & (sel_or ? {sys_bits{1'b1}} : req_i.operand_m)) |
        ((sel_or ? {sys_bits{1'b1}} : req_i.operand_n)
            & (sel_inv ? ~req_i.operand_m : req_i.operand_m));

    always_comb begin
        res_o.value    = bitwise;
        res_o.carry    = flags_i.c;
        res_o.overflow = flags_i.v;
        case (req_i.op)
            op_add: begin
                res_o.value    = sum[sys_bits-1:0];
                res_o.carry    = sum[sys_bits];
                // like-signed operands giving a result of the other sign
                res_o.overflow = (req_i.operand_n[sys_bits-1] == req_i.operand_m[sys_bits-1])
                                 && (sum[sys_bits-1] != req_i.operand_n[sys_bits-1]);
            end
            op_mul:  res_o.value = product;
            default: res_o.value = bitwise;
        endcase
    end

endmodule

// ==== src/reg_file.sv ====
// register file: sixteen words plus nzcv, two combinational reads, commit on the edge
`timescale 1ns/1ps

module reg_file import core_types_pkg::*; (
    input  logic      rst,
    input  logic      reset,
    input  reg_idx_t  rd_idx_n_i,
    input  reg_idx_t  rd_idx_m_i,
    output word_t     rd_data_n_o,
    output word_t     rd_data_m_o,
    input  exec_req_t req_i,
    input  exec_res_t res_i,
    output wb_t       wb_o,
    output flags_t    flags_o
);

    word_t    regs [reg_count];
    flags_t   flags_q;
    logic     wb_valid_q;
    logic     wb_we_q;
    reg_idx_t wb_dest_q;
    word_t    wb_value_q;

    assign rd_data_n_o = regs[rd_idx_n_i];
    assign rd_data_m_o = regs[rd_idx_m_i];
    assign flags_o     = flags_q;
    assign wb_o        = '{valid:    wb_valid_q,
                           write_en: wb_we_q,
                           dest:     wb_dest_q,
                           value:    wb_value_q};

    always_ff @(posedge rst) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
            flags_q    <= '0;
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= req_i.valid;
            if (req_i.valid && req_i.write_en) begin
                regs[req_i.dest] <= res_i.value;
            end
            // n and z come from the value, c and v from the unit
            if (req_i.valid && req_i.set_flags) begin
                flags_q.n <= res_i.value[sys_bits-1];
                flags_q.z <= (res_i.value == '0);
                flags_q.c <= res_i.carry;
                flags_q.v <= res_i.overflow;
            end
        end
    end

    // writeback payload, held until the next commit
    always_ff @(posedge rst) begin
        if (req_i.valid) begin
            wb_we_q    <= req_i.write_en;
            wb_dest_q  <= req_i.dest;
            wb_value_q <= res_i.value;
        end
    end

endmodule

// ==== src/thumb_core.sv ====
// thumb execution core: decoder, shifter and alu feeding the register file
`timescale 1ns/1ps

module thumb_core import thumb_isa_pkg::*, core_types_pkg::*; (
    input  logic   rst,
    input  logic   reset,
    input  cmd_t   cmd_i,
    input  logic   cmd_valid_i,
    output wb_t    wb_o,
    output flags_t flags_o
);

    reg_idx_t  rd_idx_n;
    reg_idx_t  rd_idx_m;
    word_t     rd_data_n;
    word_t     rd_data_m;
    exec_req_t req;
    exec_res_t shift_res;
    exec_res_t alu_res;
    exec_res_t res;

    thumb_decoder u_decoder (
        .cmd_i       (cmd_i),
        .cmd_valid_i (cmd_valid_i),
        .flags_i     (flags_o),
        .rd_data_n_i (rd_data_n),
        .rd_data_m_i (rd_data_m),
        .rd_idx_n_o  (rd_idx_n),
        .rd_idx_m_o  (rd_idx_m),
        .req_o       (req)
    );

    barrel_shifter u_shifter (
        .req_i   (req),
        .flags_i (flags_o),
        .res_o   (shift_res)
    );

    arith_logic_unit u_alu (
        .req_i   (req),
        .flags_i (flags_o),
        .res_o   (alu_res)
    );

    // both units see every request, the op decides whose result commits
    assign res = is_shift_op(req.op) ? shift_res : alu_res;

    reg_file u_regs (
        .rst         (rst),
        .reset       (reset),
        .rd_idx_n_i  (rd_idx_n),
        .rd_idx_m_i  (rd_idx_m),
        .rd_data_n_o (rd_data_n),
        .rd_data_m_o (rd_data_m),
        .req_i       (req),
        .res_i       (res),
        .wb_o        (wb_o),
        .flags_o     (flags_o)
    );

endmodule

// ==== dv/thumb_core_assert.sv ====
// thumb core port checks: writeback strobe timing and flag stability
`timescale 1ns/1ps

module thumb_core_assert import core_types_pkg::*; (
    input logic   rst,
    input logic   reset,
    input logic   cmd_valid_i,
    input wb_t    wb_i,
    input flags_t flags_i
);

    // nothing commits while reset is held
    a_quiet_after_reset: assert property (@(posedge rst) reset |=> !wb_i.valid)
        else $error("wb_o.valid high in the cycle after reset");

    // one cycle of latency from strobe to writeback
    a_valid_needs_strobe: assert property (
        @(posedge rst) disable iff (reset) wb_i.valid |-> $past(cmd_valid_i))
        else $error("wb_o.valid without a cmd_valid_i strobe the cycle before");

    a_flags_hold: assert property (
        @(posedge rst) disable iff (reset) !wb_i.valid |-> $stable(flags_i))
        else $error("flags_o changed without a writeback");

endmodule

bind thumb_core thumb_core_assert u_assert (
    .rst         (rst),
    .reset       (reset),
    .cmd_valid_i (cmd_valid_i),
    .wb_i        (wb_o),
    .flags_i     (flags_o)
);

// ==== dv/thumb_core_tb.sv ====
// thumb core testbench: table of commands with hand-worked writeback and flag values
`timescale 1ns/1ps

module thumb_core_tb import thumb_isa_pkg::*, core_types_pkg::*;;

    typedef struct packed {
        cmd_t   cmd;
        logic   strobe;
        wb_t    wb;
        flags_t flags;
    } step_t;

    logic   rst;
    logic   reset;
    cmd_t   cmd_i;
    logic   cmd_valid_i;
    wb_t    wb_o;
    flags_t flags_o;

    step_t  steps[$];
    int     valid_expected;
    int     valid_seen;

    thumb_core uut (
        .rst         (rst),
        .reset       (reset),
        .cmd_i       (cmd_i),
        .cmd_valid_i (cmd_valid_i),
        .wb_o        (wb_o),
        .flags_o     (flags_o)
    );

    initial begin
        rst = 1'b0;
        forever #2 rst = ~rst;
    end

    // every writeback pulse, sampled half a cycle after the edge
    initial begin
        valid_seen = 0;
        forever begin
            @(posedge rst);
            #2;
            if (wb_o.valid === 1'b1) begin
                valid_seen++;
            end
        end
    end

    function automatic cmd_t enc_shift(logic [1:0] kind, logic [4:0] imm5, logic [2:0] rm,
                                       logic [2:0] rd);
        return {3'b000, kind, imm5, rm, rd};
    endfunction

    function automatic cmd_t enc_add_sub(logic imm, logic sub, logic [2:0] m, logic [2:0] rn,
                                         logic [2:0] rd);
        return {5'b00011, imm, sub, m, rn, rd};
    endfunction

    function automatic cmd_t enc_imm8(logic [1:0] mode, logic [2:0] rd, logic [7:0] imm);
        return {3'b001, mode, rd, imm};
    endfunction

    function automatic cmd_t enc_dp(logic [3:0] op, logic [2:0] rm, logic [2:0] rdn);
        return {6'b010000, op, rm, rdn};
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: wb_o got %h expected %h", got, exp));
        end
    endtask

    task automatic check_flags(input flags_t got, input flags_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: flags_o got %h expected %h", got, exp));
        end
    endtask

    task automatic expect_commit(input cmd_t cmd, input logic we, input reg_idx_t dest,
                                 input word_t value, input logic [3:0] nzcv);
        step_t s;
        s.cmd    = cmd;
        s.strobe = 1'b1;
        s.wb     = '{valid: 1'b1, write_en: we, dest: dest, value: value};
        s.flags  = nzcv;
        steps.push_back(s);
        valid_expected++;
    endtask

    task automatic expect_no_commit(input cmd_t cmd, input logic strobe,
                                    input logic [3:0] nzcv);
        step_t s;
        s.cmd    = cmd;
        s.strobe = strobe;
        s.wb     = '0;
        s.flags  = nzcv;
        steps.push_back(s);
    endtask

    // worked by hand from all-zero registers, flags given as nzcv
    task automatic build_table();
        // each low register read back through add #0
        for (int r = 0; r < 8; r++) begin
            expect_commit(enc_add_sub(1'b1, 1'b0, 3'd0, 3'(r), 3'(r)), 1'b1, reg_idx_t'(r),
                          32'h0, 4'b0100);
        end
        expect_commit(enc_imm8(imm8_mov, 3'd0, 8'h05), 1'b1, 4'd0, 32'h5, 4'b0000);
        expect_commit(enc_imm8(imm8_mov, 3'd1, 8'h01), 1'b1, 4'd1, 32'h1, 4'b0000);
        expect_commit(enc_imm8(imm8_sub, 3'd2, 8'h01), 1'b1, 4'd2, 32'hffff_ffff, 4'b1000);
        expect_commit(enc_imm8(imm8_add, 3'd2, 8'h01), 1'b1, 4'd2, 32'h0, 4'b0110);
        expect_commit(enc_imm8(imm8_cmp, 3'd0, 8'h05), 1'b0, 4'd0, 32'h0, 4'b0110);
        expect_commit(enc_imm8(imm8_cmp, 3'd0, 8'h06), 1'b0, 4'd0, 32'hffff_ffff, 4'b1000);
        expect_commit(enc_add_sub(1'b1, 1'b0, 3'd0, 3'd0, 3'd3), 1'b1, 4'd3, 32'h5, 4'b0000);
        // signed overflow around 0x7fffffff
        expect_commit(enc_imm8(imm8_mov, 3'd4, 8'h01), 1'b1, 4'd4, 32'h1, 4'b0000);
        expect_commit(enc_shift(sh_lsl, 5'd31, 3'd4, 3'd4), 1'b1, 4'd4, 32'h8000_0000, 4'b1000);
        expect_commit(enc_add_sub(1'b1, 1'b1, 3'd1, 3'd4, 3'd4), 1'b1, 4'd4, 32'h7fff_ffff, 4'b0011);
        expect_commit(enc_add_sub(1'b0, 1'b0, 3'd1, 3'd4, 3'd5), 1'b1, 4'd5, 32'h8000_0000, 4'b1001);
        expect_commit(enc_add_sub(1'b0, 1'b1, 3'd1, 3'd5, 3'd6), 1'b1, 4'd6, 32'h7fff_ffff, 4'b0011);
        expect_commit(enc_dp(dp_adc, 3'd1, 3'd3), 1'b1, 4'd3, 32'h7, 4'b0000);
        expect_commit(enc_dp(dp_sbc, 3'd1, 3'd3), 1'b1, 4'd3, 32'h5, 4'b0010);
        expect_commit(enc_dp(dp_sbc, 3'd1, 3'd3), 1'b1, 4'd3, 32'h4, 4'b0010);
        // shifts, zero amounts keep c
        expect_commit(enc_shift(sh_lsr, 5'd1, 3'd0, 3'd2), 1'b1, 4'd2, 32'h2, 4'b0010);
        expect_commit(enc_shift(sh_lsl, 5'd0, 3'd0, 3'd2), 1'b1, 4'd2, 32'h5, 4'b0010);
        expect_commit(enc_shift(sh_lsl, 5'd1, 3'd5, 3'd2), 1'b1, 4'd2, 32'h0, 4'b0110);
        expect_commit(enc_shift(sh_asr, 5'd4, 3'd5, 3'd2), 1'b1, 4'd2, 32'hf800_0000, 4'b1000);
        expect_commit(enc_imm8(imm8_mov, 3'd7, 8'h20), 1'b1, 4'd7, 32'h20, 4'b0000);
        expect_commit(enc_dp(dp_lsr, 3'd7, 3'd5), 1'b1, 4'd5, 32'h0, 4'b0110);
        expect_commit(enc_imm8(imm8_mov, 3'd7, 8'h28), 1'b1, 4'd7, 32'h28, 4'b0000);
        expect_commit(enc_dp(dp_asr, 3'd7, 3'd2), 1'b1, 4'd2, 32'hffff_ffff, 4'b1010);
        expect_commit(enc_dp(dp_lsl, 3'd7, 3'd3), 1'b1, 4'd3, 32'h0, 4'b0100);
        expect_commit(enc_dp(dp_ror, 3'd1, 3'd0), 1'b1, 4'd0, 32'h8000_0002, 4'b1010);
        expect_commit(enc_dp(dp_lsr, 3'd5, 3'd4), 1'b1, 4'd4, 32'h7fff_ffff, 4'b0010);
        // logic ops and mul with c and v both set beforehand
        expect_commit(enc_add_sub(1'b1, 1'b1, 3'd3, 3'd0, 3'd5), 1'b1, 4'd5, 32'h7fff_ffff, 4'b0011);
        expect_commit(enc_dp(dp_and, 3'd0, 3'd5), 1'b1, 4'd5, 32'h2, 4'b0011);
        expect_commit(enc_dp(dp_eor, 3'd2, 3'd5), 1'b1, 4'd5, 32'hffff_fffd, 4'b1011);
        expect_commit(enc_dp(dp_orr, 3'd1, 3'd3), 1'b1, 4'd3, 32'h1, 4'b0011);
        expect_commit(enc_dp(dp_bic, 3'd1, 3'd5), 1'b1, 4'd5, 32'hffff_fffc, 4'b1011);
        expect_commit(enc_dp(dp_tst, 3'd1, 3'd5), 1'b0, 4'd5, 32'h0, 4'b0111);
        expect_commit(enc_dp(dp_mvn, 3'd4, 3'd3), 1'b1, 4'd3, 32'h8000_0000, 4'b1011);
        expect_commit(enc_dp(dp_mul, 3'd4, 3'd2), 1'b1, 4'd2, 32'h8000_0001, 4'b1011);
        expect_commit(enc_dp(dp_rsb, 3'd1, 3'd6), 1'b1, 4'd6, 32'hffff_ffff, 4'b1000);
        expect_commit(enc_dp(dp_cmn, 3'd1, 3'd6), 1'b0, 4'd6, 32'h0, 4'b0110);
        expect_commit(enc_dp(dp_cmp, 3'd6, 3'd1), 1'b0, 4'd1, 32'h2, 4'b0000);
        // branch and hi-register encodings are ignored, an unstrobed mov does nothing
        expect_no_commit(16'he000, 1'b1, 4'b0000);
        expect_no_commit(enc_imm8(imm8_mov, 3'd1, 8'h77), 1'b0, 4'b0000);
        expect_no_commit(16'h4700, 1'b1, 4'b0000);
        expect_commit(enc_add_sub(1'b1, 1'b0, 3'd0, 3'd1, 3'd4), 1'b1, 4'd4, 32'h1, 4'b0000);
        expect_commit(enc_add_sub(1'b1, 1'b0, 3'd0, 3'd5, 3'd0), 1'b1, 4'd0, 32'hffff_fffc, 4'b1000);
    endtask

    task automatic wait_commit(input int limit);
        for (int i = 0; i < limit; i++) begin
            @(posedge rst);
            #1;
            cmd_valid_i = 1'b0;
            if (wb_o.valid === 1'b1) begin
                return;
            end
        end
        abort_run("timed out waiting for wb_o.valid");
    endtask

    task automatic hold_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge rst);
            #1;
            cmd_valid_i = 1'b0;
            if (wb_o.valid !== 1'b0) begin
                abort_run("wb_o.valid rose for a command that must not commit");
            end
        end
    endtask

    initial begin
        step_t s;
        reset          = 1'b1;
        cmd_i          = '0;
        cmd_valid_i    = 1'b0;
        valid_expected = 0;
        build_table();
        repeat (4) @(posedge rst);
        #1;
        reset = 1'b0;
        if (wb_o.valid !== 1'b0) begin
            abort_run("wb_o.valid is high right after reset");
        end
        check_flags(flags_o, '0);
        // strobed entries follow each other with no idle cycle
        foreach (steps[i]) begin
            s           = steps[i];
            cmd_i       = s.cmd;
            cmd_valid_i = s.strobe;
            if (s.wb.valid) begin
                wait_commit(8);
                check_wb(wb_o, s.wb);
            end else begin
                hold_quiet(2);
            end
            check_flags(flags_o, s.flags);
        end
        hold_quiet(2);
        if (valid_seen == valid_expected) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run($sformatf("saw %0d writeback pulses for %0d committing commands",
                                valid_seen, valid_expected));
        end
    end

endmodule

// ==== sim.f ====
src/thumb_isa_pkg.sv
src/core_types_pkg.sv
src/thumb_decoder.sv
src/barrel_shifter.sv
src/arith_logic_unit.sv
src/reg_file.sv
src/thumb_core.sv
dv/thumb_core_assert.sv
dv/thumb_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the thumb core testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module thumb_core_tb -f sim.f -o thumb_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/thumb_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" sim.log; then
    exit 0
fi
exit 1
